// File: env_defines.svh
/*
 * Fixed sizes for the 18-slot envelope bank.
 * Included by the package and by every module that sizes a port or a store.
 */
`ifndef ENV_DEFINES_SVH
`define ENV_DEFINES_SVH

// slot addressing
`define ENV_NUM_SLOTS 18    // operator slots per bank
`define ENV_SLOT_W    5     // enough for 0..17

// attenuation
`define ENV_LEVEL_W   9     // 0 = loudest
`define ENV_SILENCE   511   // full attenuation

// register fields
`define ENV_RATE_W    4     // ar, dr, rr and sl
`define ENV_TL_W      6     // total level, 0.75 dB steps

// rate generation
`define ENV_COUNT_W   15    // shared sample counter
`define ENV_STEP_W    4     // per-sample step, up to 8

`endif

// File: env_pkg.sv
/*
 * Types shared by the envelope stages: state and command encodings
 * and the records handed from decode to execute and from execute to result.
 */
`include "env_defines.svh"

package env_pkg;

    // one-hot so the per-slot state store decodes cheaply
    typedef enum logic [3:0] {
        ST_ATTACK  = 4'b0001,
        ST_DECAY   = 4'b0010,
        ST_SUSTAIN = 4'b0100,
        ST_RELEASE = 4'b1000
    } env_state_e;

    typedef enum logic [1:0] {
        CMD_NONE    = 2'd0,
        CMD_KEY_ON  = 2'd1,
        CMD_KEY_OFF = 2'd2
    } env_cmd_e;

    typedef struct packed {
        logic [`ENV_RATE_W-1:0] ar;     // attack rate
        logic [`ENV_RATE_W-1:0] dr;     // decay rate
        logic [`ENV_RATE_W-1:0] sl;     // sustain level, compared to level >> 4
        logic [`ENV_RATE_W-1:0] rr;     // release rate
        logic [`ENV_TL_W-1:0]   tl;     // total level
        logic                   egt;    // 1 = hold in sustain
    } env_regs_t;

    typedef struct packed {
        logic [`ENV_STEP_W-1:0] attack;
        logic [`ENV_STEP_W-1:0] decay;
        logic [`ENV_STEP_W-1:0] release_;  // release is a keyword
    } env_steps_t;

    typedef struct packed {
        logic [`ENV_SLOT_W-1:0] slot;
        env_cmd_e               cmd;
        env_regs_t              regs;
        env_steps_t             steps;
    } env_req_t;

    typedef struct packed {
        logic [`ENV_SLOT_W-1:0]  slot;
        logic [`ENV_LEVEL_W-1:0] level;    // updated envelope level
        logic [`ENV_TL_W-1:0]    tl;       // carried on to the result stage
    } env_lvl_t;

endpackage

// File: env_rate_counter.sv
/*
 * Sample counter shared by all slots plus rate to step conversion.
 * Advances once per round; slow rates only step when the counter hits a boundary.
 */
`include "env_defines.svh"

module env_rate_counter (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   adv,     // one pulse per round
    input  logic [`ENV_RATE_W-1:0] ar,
    input  logic [`ENV_RATE_W-1:0] dr,
    input  logic [`ENV_RATE_W-1:0] rr,
    output env_pkg::env_steps_t    steps
);

    logic [`ENV_COUNT_W-1:0] count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (adv) begin
            count <= count + 1'b1;     // wraps freely
        end
    end

    // step for one rate against the current count
    function automatic logic [`ENV_STEP_W-1:0] rate_to_step(
        input logic [`ENV_RATE_W-1:0]  r,
        input logic [`ENV_COUNT_W-1:0] cnt
    );
        logic [`ENV_COUNT_W-1:0] mask;
        logic [`ENV_STEP_W-1:0]  step;
        mask = {`ENV_COUNT_W{1'b1}} >> (r + 3);   // low (12 - r) bits set
        if (r == '0) begin
            step = '0;                            // rate 0 never moves
        end else if (r >= 4'd12) begin
            step = 4'b0001 << r[1:0];             // r[1:0] is r - 12 here
        end else if ((cnt & mask) == '0) begin
            step = 4'd1;                          // counter boundary reached
        end else begin
            step = '0;
        end
        return step;
    endfunction

    always_comb begin
        steps.attack   = rate_to_step(ar, count);
        steps.decay    = rate_to_step(dr, count);
        steps.release_ = rate_to_step(rr, count);
    end

endmodule

// File: env_decode.sv
/*
 * First stage. Captures the slot strobe, turns the key pulses into one command
 * and attaches the attack, decay and release steps for this round.
 * Output record is valid one cycle after sample_en.
 */
`include "env_defines.svh"

module env_decode (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   sample_en,   // one slot per strobe
    input  logic                   key_on,      // pulse, only with sample_en
    input  logic                   key_off,     // pulse, only with sample_en
    input  logic [`ENV_SLOT_W-1:0] slot,
    input  env_pkg::env_regs_t     regs,
    output logic                   req_valid,
    output env_pkg::env_req_t      req
);

    env_pkg::env_cmd_e   cmd;
    env_pkg::env_steps_t steps;
    logic                adv;

    // last slot of the round bumps the counter at the same edge it is sampled
    assign adv = sample_en && (slot == `ENV_SLOT_W'(`ENV_NUM_SLOTS - 1));

    env_rate_counter rate_counter_i (
        .clk    (clk),
        .arst_n (arst_n),
        .adv    (adv),
        .ar     (regs.ar),
        .dr     (regs.dr),
        .rr     (regs.rr),
        .steps  (steps)
    );

    // key_on has priority when both arrive together
    always_comb begin
        if (key_on) begin
            cmd = env_pkg::CMD_KEY_ON;
        end else if (key_off) begin
            cmd = env_pkg::CMD_KEY_OFF;
        end else begin
            cmd = env_pkg::CMD_NONE;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= sample_en;
        end
    end

    // payload only loads on a strobe
    always_ff @(posedge clk) begin
        if (sample_en) begin
            req.slot  <= slot;
            req.cmd   <= cmd;
            req.regs  <= regs;
            req.steps <= steps;   // counter value before this edge
        end
    end

endmodule

// File: env_execute.sv
/*
 * Second stage. Holds state and level per slot, runs the ADSR machine
 * and writes the updated level back in the same cycle it is forwarded.
 * Store is read combinationally by req.slot and written at the next edge.
 */
`include "env_defines.svh"

module env_execute (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req_valid,
    input  env_pkg::env_req_t req,
    output logic              lvl_valid,
    output env_pkg::env_lvl_t lvl
);

    env_pkg::env_state_e     state_mem [`ENV_NUM_SLOTS];
    logic [`ENV_LEVEL_W-1:0] level_mem [`ENV_NUM_SLOTS];

    env_pkg::env_state_e     cur_state;
    env_pkg::env_state_e     nxt_state;
    logic [`ENV_LEVEL_W-1:0] cur_level;
    logic [`ENV_LEVEL_W-1:0] nxt_level;
    logic [`ENV_STEP_W-1:0]  step;
    logic [12:0]             att_prod;   // level * step, up to 511 * 8
    logic [12:0]             att_dec;    // amount removed in attack
    logic [`ENV_LEVEL_W:0]   rise;       // one spare bit for the cap test

    assign cur_state = state_mem[req.slot];
    assign cur_level = level_mem[req.slot];

    // next state from stored state and key command
    always_comb begin
        case (req.cmd)
            env_pkg::CMD_KEY_ON:  nxt_state = env_pkg::ST_ATTACK;
            env_pkg::CMD_KEY_OFF: nxt_state = env_pkg::ST_RELEASE;
            default: begin
                case (cur_state)
                    env_pkg::ST_ATTACK:
                        nxt_state = (cur_level == '0) ? env_pkg::ST_DECAY
                                                      : env_pkg::ST_ATTACK;
                    env_pkg::ST_DECAY:
                        nxt_state = ((cur_level >> 4) >= req.regs.sl) ? env_pkg::ST_SUSTAIN
                                                                      : env_pkg::ST_DECAY;
                    env_pkg::ST_SUSTAIN:
                        nxt_state = req.regs.egt ? env_pkg::ST_SUSTAIN
                                                 : env_pkg::ST_RELEASE;
                    default:
                        nxt_state = env_pkg::ST_RELEASE;   // release is terminal
                endcase
            end
        endcase
    end

    // step follows the new state
    always_comb begin
        case (nxt_state)
            env_pkg::ST_ATTACK:  step = req.steps.attack;
            env_pkg::ST_DECAY:   step = req.steps.decay;
            env_pkg::ST_RELEASE: step = req.steps.release_;
            default:             step = '0;   // sustain holds
        endcase
    end

    // level arithmetic
    always_comb begin
        att_prod  = 13'(cur_level) * 13'(step);
        att_dec   = (att_prod >> 3) + 13'd1;
        rise      = {1'b0, cur_level} + (`ENV_LEVEL_W + 1)'(step);
        nxt_level = cur_level;
        case (nxt_state)
            env_pkg::ST_ATTACK: begin
                if (step != '0 && cur_level != '0) begin
                    if (att_dec >= 13'(cur_level)) begin
                        nxt_level = '0;                           // floor
                    end else begin
                        nxt_level = cur_level - `ENV_LEVEL_W'(att_dec);
                    end
                end
            end
            env_pkg::ST_DECAY, env_pkg::ST_RELEASE: begin
                if (rise > (`ENV_LEVEL_W + 1)'(`ENV_SILENCE)) begin
                    nxt_level = `ENV_LEVEL_W'(`ENV_SILENCE);      // cap
                end else begin
                    nxt_level = rise[`ENV_LEVEL_W-1:0];
                end
            end
            default: nxt_level = cur_level;
        endcase
    end

    // per-slot store, back to silent release on reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `ENV_NUM_SLOTS; i++) begin
                state_mem[i] <= env_pkg::ST_RELEASE;
                level_mem[i] <= `ENV_LEVEL_W'(`ENV_SILENCE);
            end
        end else if (req_valid) begin
            state_mem[req.slot] <= nxt_state;
            level_mem[req.slot] <= nxt_level;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lvl_valid <= 1'b0;
        end else begin
            lvl_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            lvl.slot  <= req.slot;
            lvl.level <= nxt_level;   // same value that was written back
            lvl.tl    <= req.regs.tl;
        end
    end

endmodule

// File: env_result.sv
/*
 * Last stage. Adds total-level attenuation to the envelope level,
 * clamps at silence and registers the output strobe with its slot.
 */
`include "env_defines.svh"

module env_result (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    lvl_valid,
    input  env_pkg::env_lvl_t       lvl,
    output logic                    out_valid,
    output logic [`ENV_SLOT_W-1:0]  out_slot,
    output logic [`ENV_LEVEL_W-1:0] env_out
);

    logic [`ENV_LEVEL_W:0]   sum;       // 511 + 4 * 63 fits in 10 bits
    logic [`ENV_LEVEL_W-1:0] clamped;

    always_comb begin
        sum = {1'b0, lvl.level} + ((`ENV_LEVEL_W + 1)'(lvl.tl) << 2);   // tl in 0.75 dB
        if (sum > (`ENV_LEVEL_W + 1)'(`ENV_SILENCE)) begin
            clamped = `ENV_LEVEL_W'(`ENV_SILENCE);
        end else begin
            clamped = sum[`ENV_LEVEL_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= lvl_valid;
        end
    end

    // slot and value only move with a strobe
    always_ff @(posedge clk) begin
        if (lvl_valid) begin
            out_slot <= lvl.slot;
            env_out  <= clamped;
        end
    end

endmodule

// File: env_gen_top.sv
/*
 * Envelope generator for an 18-slot operator bank.
 * Three registered stages: decode, execute, result.
 * A sample_en strobe comes out as out_valid three cycles later, same slot.
 */
`include "env_defines.svh"

module env_gen_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    sample_en,
    input  logic                    key_on,
    input  logic                    key_off,
    input  logic [`ENV_SLOT_W-1:0]  slot,
    input  env_pkg::env_regs_t      regs,
    output logic                    out_valid,
    output logic [`ENV_SLOT_W-1:0]  out_slot,
    output logic [`ENV_LEVEL_W-1:0] env_out
);

    logic              req_valid;
    env_pkg::env_req_t req;
    logic              lvl_valid;
    env_pkg::env_lvl_t lvl;

    env_decode decode_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .sample_en (sample_en),
        .key_on    (key_on),
        .key_off   (key_off),
        .slot      (slot),
        .regs      (regs),
        .req_valid (req_valid),
        .req       (req)
    );

    env_execute execute_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .lvl_valid (lvl_valid),
        .lvl       (lvl)
    );

    env_result result_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .lvl_valid (lvl_valid),
        .lvl       (lvl),
        .out_valid (out_valid),
        .out_slot  (out_slot),
        .env_out   (env_out)
    );

endmodule

// File: env_gen_chk.sv
/*
 * Timing and range assertions for the envelope top level, bound into env_gen_top.
 * fail_cnt holds the number of assertions that have fired.
 */
`include "env_defines.svh"

module env_gen_chk (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    sample_en,
    input logic                    out_valid,
    input logic [`ENV_LEVEL_W-1:0] env_out
);

    int fail_cnt = 0;

    a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else begin
            fail_cnt++;
            $error("out_valid high while arst_n is low");
        end

    // three register stages, one strobe in gives one strobe out
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(sample_en, 3))
        else begin
            fail_cnt++;
            $error("out_valid does not follow sample_en by 3 cycles");
        end

    a_range: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> (!$isunknown(env_out) && env_out <= `ENV_SILENCE))
        else begin
            fail_cnt++;
            $error("env_out unknown or above silence");
        end

endmodule

bind env_gen_top env_gen_chk env_gen_chk_i (.*);

// File: env_gen_tb.sv
/*
 * Testbench for the envelope generator. Runs rounds of 18 slot strobes,
 * predicts each output with a reference model and checks it in a separate process.
 */
`include "env_defines.svh"

module env_gen_tb;

    typedef struct packed {
        logic [`ENV_SLOT_W-1:0]  slot;
        logic [`ENV_LEVEL_W-1:0] level;
    } exp_t;

    localparam int NUM_ROUNDS     = 401;                        // rounds over all tests
    localparam int TIMEOUT_CYCLES = NUM_ROUNDS * 20 + 2000;

    logic                    clk;
    logic                    arst_n;
    logic                    sample_en;
    logic                    key_on;
    logic                    key_off;
    logic [`ENV_SLOT_W-1:0]  slot;
    env_pkg::env_regs_t      regs;
    logic                    out_valid;
    logic [`ENV_SLOT_W-1:0]  out_slot;
    logic [`ENV_LEVEL_W-1:0] env_out;

    env_pkg::env_state_e m_state [`ENV_NUM_SLOTS];   // model state per slot
    int                  m_level [`ENV_NUM_SLOTS];
    int                  m_count;                    // model sample counter
    env_pkg::env_regs_t  slot_regs [`ENV_NUM_SLOTS]; // registers for the next round
    exp_t                exp_q [$];
    int errs = 0;
    int errs_base = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int chk_fails = 0;
    int cycles = 0;

    env_gen_top env_gen_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, the test sequence never finished", cycles);
        $display("Test FAILED");
        $finish;
    end

    function automatic int rate_step(input logic [3:0] r);
        if (r == 0) return 0;
        if (r >= 12) return 1 << (r - 12);
        return ((m_count % (1 << (12 - r))) == 0) ? 1 : 0;   // slow rates gated
    endfunction

    // applies one strobe to the model and returns the expected env_out
    function automatic logic [`ENV_LEVEL_W-1:0] model_strobe(input int s, input logic kon,
                                                             input logic koff,
                                                             input env_pkg::env_regs_t r);
        env_pkg::env_state_e nxt;
        int lvl;
        int sum;
        lvl = m_level[s];
        nxt = m_state[s];
        if (kon) nxt = env_pkg::ST_ATTACK;
        else if (koff) nxt = env_pkg::ST_RELEASE;
        else if (nxt == env_pkg::ST_ATTACK && lvl == 0) nxt = env_pkg::ST_DECAY;
        else if (nxt == env_pkg::ST_DECAY && (lvl / 16) >= r.sl) nxt = env_pkg::ST_SUSTAIN;
        else if (nxt == env_pkg::ST_SUSTAIN && !r.egt) nxt = env_pkg::ST_RELEASE;
        case (nxt)
            env_pkg::ST_ATTACK: begin
                if (rate_step(r.ar) != 0 && lvl != 0) begin
                    lvl = lvl - ((lvl * rate_step(r.ar)) / 8) - 1;
                    if (lvl < 0) lvl = 0;
                end
            end
            env_pkg::ST_DECAY:   lvl = lvl + rate_step(r.dr);
            env_pkg::ST_RELEASE: lvl = lvl + rate_step(r.rr);
            default:             lvl = lvl;                   // sustain holds
        endcase
        if (lvl > `ENV_SILENCE) lvl = `ENV_SILENCE;
        m_state[s] = nxt;
        m_level[s] = lvl;
        if (s == `ENV_NUM_SLOTS - 1) m_count = (m_count + 1) % (1 << `ENV_COUNT_W);
        sum = lvl + 4 * r.tl;
        return (sum > `ENV_SILENCE) ? `ENV_SILENCE : sum;
    endfunction

    function automatic env_pkg::env_regs_t make_regs(input int ar, dr, sl, rr, tl,
                                                     input bit egt);
        return {4'(ar), 4'(dr), 4'(sl), 4'(rr), 6'(tl), egt};   // field order of the struct
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            errs++;
        end
    endtask

    task automatic send(input int s, input logic kon, input logic koff,
                        input env_pkg::env_regs_t r);
        exp_t e;
        sample_en = 1'b1;
        slot      = s[`ENV_SLOT_W-1:0];
        key_on    = kon;
        key_off   = koff;
        regs      = r;
        e.slot    = s[`ENV_SLOT_W-1:0];
        e.level   = model_strobe(s, kon, koff, r);
        exp_q.push_back(e);
        @(posedge clk);
        #1;
        sample_en = 1'b0;
        key_on    = 1'b0;
        key_off   = 1'b0;
    endtask

    task automatic run_round(input logic [`ENV_NUM_SLOTS-1:0] kon,
                             input logic [`ENV_NUM_SLOTS-1:0] koff, input bit gaps);
        for (int s = 0; s < `ENV_NUM_SLOTS; s++) begin
            send(s, kon[s], koff[s], slot_regs[s]);
            if (gaps && ($urandom % 8) == 0) begin
                @(posedge clk);                               // one idle cycle
                #1;
            end
        end
    endtask

    task automatic end_test(input string name);
        int n = 0;
        while (exp_q.size() != 0 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("missing out_valid, %0d strobes never came out", exp_q.size());
            errs++;
            exp_q.delete();
        end
        repeat (4) @(posedge clk);                            // room for stray strobes
        #1;
        if (errs == errs_base) begin
            pass_cnt++;
            $display("%-12s passed", name);
        end else begin
            fail_cnt++;
            $display("%-12s failed with %0d errors", name, errs - errs_base);
        end
        errs_base = errs;
    endtask

    // outputs sampled on the falling edge, away from the register updates
    always @(negedge clk) begin
        exp_t e;
        if (arst_n && out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("unexpected out_valid for slot %0d with no strobe pending", out_slot);
                errs++;
            end else begin
                e = exp_q.pop_front();
                check_value("out_slot", out_slot, e.slot);
                check_value("env_out", env_out, e.level);
            end
        end
    end

    initial begin
        logic [`ENV_NUM_SLOTS-1:0] kon;
        logic [`ENV_NUM_SLOTS-1:0] koff;
        arst_n    = 1'b0;
        sample_en = 1'b0;
        key_on    = 1'b0;
        key_off   = 1'b0;
        slot      = '0;
        regs      = '0;
        void'($urandom(32'h545));
        m_count   = 0;
        for (int s = 0; s < `ENV_NUM_SLOTS; s++) begin
            m_state[s]   = env_pkg::ST_RELEASE;
            m_level[s]   = `ENV_SILENCE;
            slot_regs[s] = make_regs(0, 0, 0, 0, 0, 1);
        end
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        run_round('0, '0, 0);                                 // every slot silent
        end_test("idle");

        slot_regs[0] = make_regs(15, 0, 0, 0, 0, 1);          // floors at 0 in one step
        slot_regs[1] = make_regs(10, 0, 15, 0, 0, 1);
        slot_regs[2] = make_regs(14, 0, 15, 0, 0, 1);
        run_round(18'h00007, '0, 0);
        repeat (11) run_round('0, '0, 0);
        end_test("attack");

        slot_regs[3] = make_regs(15, 15, 2, 0, 0, 1);
        slot_regs[4] = make_regs(15, 13, 1, 0, 0, 1);
        slot_regs[5] = make_regs(15, 15, 2, 12, 0, 0);        // falls through to release
        run_round(18'h00038, '0, 0);
        repeat (19) run_round('0, '0, 0);
        end_test("decay");

        slot_regs[1] = make_regs(10, 0, 15, 13, 0, 1);
        slot_regs[3] = make_regs(15, 15, 2, 15, 0, 1);
        slot_regs[4] = make_regs(15, 13, 1, 14, 0, 1);
        slot_regs[8] = make_regs(15, 0, 0, 0, 0, 1);          // both keys, attack wins
        run_round(18'h00100, 18'h0011a, 0);
        repeat (63) run_round('0, '0, 0);
        end_test("release");

        slot_regs[3]  = make_regs(15, 15, 2, 15, 40, 1);
        slot_regs[8]  = make_regs(15, 0, 0, 0, 63, 1);
        slot_regs[9]  = make_regs(15, 0, 0, 0, 20, 1);
        slot_regs[10] = make_regs(0, 0, 0, 0, 63, 1);
        slot_regs[11] = make_regs(12, 0, 15, 0, 63, 1);
        run_round(18'h00a00, '0, 0);
        repeat (3) run_round('0, '0, 0);
        end_test("total_level");

        for (int rnd = 0; rnd < 300; rnd++) begin
            for (int s = 0; s < `ENV_NUM_SLOTS; s++) begin
                slot_regs[s] = env_pkg::env_regs_t'($urandom);
                kon[s]       = ($urandom % 16) == 0;
                koff[s]      = ($urandom % 16) == 0;
            end
            run_round(kon, koff, 1);
        end
        end_test("soak");

        chk_fails = env_gen_top_i.env_gen_chk_i.fail_cnt;
        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 pass_cnt, fail_cnt, chk_fails);
        if (fail_cnt == 0 && chk_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
env_pkg.sv
env_rate_counter.sv
env_decode.sv
env_execute.sv
env_result.sv
env_gen_top.sv
env_gen_chk.sv
env_gen_tb.sv

// File: Bender.yml
package:
  name: env_gen

export_include_dirs:
  - .

sources:
  - files:
      - env_pkg.sv
      - env_rate_counter.sv
      - env_decode.sv
      - env_execute.sv
      - env_result.sv
      - env_gen_top.sv
  - target: test
    files:
      - env_gen_chk.sv
      - env_gen_tb.sv
